//--- files.f
design/umi_pkg.sv
design/umi_arbiter.sv
design/umi_request_buffer.sv
design/umi_output_stage.sv
design/umi_mux.sv
sim/umi_mux_chk.sv
sim/umi_mux_tb.sv

//--- sim/umi_mux_tb.sv
`timescale 1ns/1ps

module umi_mux_tb
   import umi_pkg::*;
   ();

   localparam int N               = UMI_N;
   localparam int DW              = UMI_DW;
   localparam int IW              = (N > 1) ? $clog2(N) : 1;
   localparam int CLK_PERIOD      = 4;     // ns
   localparam int RESET_CYCLES    = 16;
   localparam int DRAIN_LIMIT     = 64;    // cycles to empty slots and output
   localparam int RANDOM_CYCLES   = 400;
   localparam int DIRECTED_CYCLES = 120;   // stimulus phases of all directed tests
   localparam int NUM_TESTS       = 6;
   localparam int RUN_CYCLES      = NUM_TESTS * (RESET_CYCLES + DRAIN_LIMIT + 2)
                                    + DIRECTED_CYCLES + RANDOM_CYCLES;
   localparam int MARGIN_CYCLES   = 100;

   logic            clk;
   logic            nreset;
   arb_mode_t       mode;
   logic [N-1:0]    mask;
   logic [N-1:0]    in_valid;
   logic [N*DW-1:0] in_data;
   logic [N-1:0]    in_ready;
   logic            out_ready;
   logic            out_valid;
   logic [DW-1:0]   out_data;
   logic [IW-1:0]   out_src;

   // reference model state
   logic [N-1:0]    m_full;       // slot full flags
   logic [DW-1:0]   m_data [N];   // slot payloads
   logic [N-1:0]    m_therm;      // thermometer
   logic            m_ov;
   logic [DW-1:0]   m_od;
   logic [IW-1:0]   m_os;
   int              m_wraps;      // thermometer wraps seen
   int              m_idle;       // requesters present but nobody granted

   // per source order scoreboard
   logic [DW-1:0]   sb_mem [N][512];
   int              sb_head [N];
   int              sb_tail [N];
   int              delivered_src [1024];
   int              delivered_n;
   int              total_delivered;

   int              err_count;
   int              test_count;
   integer          seed;

   umi_mux #(.N(N), .DW(DW)) i_umi_mux (
      .clk       (clk),
      .nreset    (nreset),
      .mode      (mode),
      .mask      (mask),
      .in_valid  (in_valid),
      .in_data   (in_data),
      .in_ready  (in_ready),
      .out_ready (out_ready),
      .out_valid (out_valid),
      .out_data  (out_data),
      .out_src   (out_src)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic report_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
      err_count++;
      $display("[FAIL] %s expected 0x%0h got 0x%0h at %0t", name, exp, act, $time);
   endtask

   task automatic report_error(input string msg);
      err_count++;
      $display("error at %0t: %s", $time, msg);
   endtask

   // lowest set bit or -1 if none
   function automatic int lowest_set(input logic [N-1:0] v);
      for (int i = 0; i < N; i++)
         if (v[i])
            return i;
      return -1;
   endfunction

   task automatic reset_dut();
      nreset    = 1'b0;
      mode      = MODE_PRIORITY;
      mask      = '0;
      in_valid  = '0;
      in_data   = '0;
      out_ready = 1'b1;
      m_full    = '0;
      m_therm   = '0;
      m_ov      = 1'b0;
      m_wraps   = 0;
      m_idle    = 0;
      delivered_n = 0;
      for (int i = 0; i < N; i++)
      begin
         sb_head[i] = 0;
         sb_tail[i] = 0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      #1 nreset = 1'b1;  // released just after an edge
   endtask

   task automatic new_payloads();
      logic [31:0] rnd;
      for (int i = 0; i < N; i++)
      begin
         rnd = $random(seed);
         in_data[i*DW +: DW] = rnd[DW-1:0];
      end
   endtask

   // a packet leaving the mux must be the oldest pending one of its source
   task automatic log_delivery(input int s, input logic [DW-1:0] data);
      if (sb_head[s] == sb_tail[s])
         report_error($sformatf("packet from source %0d with nothing pending", s));
      else
      begin
         if (sb_mem[s][sb_head[s]] !== data)
            report_value("out_data", sb_mem[s][sb_head[s]], data);
         sb_head[s]++;
      end
      delivered_src[delivered_n] = s;
      delivered_n++;
      total_delivered++;
   endtask

   // checks mid cycle and steps the model over the next edge
   task automatic check_and_step();
      logic         take;
      logic         coll;
      logic [N-1:0] elig;
      logic [N-1:0] rdy;
      int           g;
      #1;
      take = !m_ov || out_ready;
      elig = m_full & ~mask & ~m_therm;
      g    = lowest_set(elig);
      rdy  = ~m_full;
      if (g >= 0 && take)
         rdy[g] = 1'b1;  // freed at this edge
      if (in_ready !== rdy)
         report_value("in_ready", rdy, in_ready);
      if (out_valid !== m_ov)
         report_value("out_valid", m_ov, out_valid);
      if (m_ov && out_data !== m_od)
         report_value("out_data", m_od, out_data);
      if (m_ov && out_src !== m_os)
         report_value("out_src", m_os, out_src);
      if (out_valid === 1'b1 && out_ready)
         log_delivery(out_src, out_data);  // what the DUT hands downstream
      coll = 1'b0;
      for (int i = 0; i < N; i++)
         if (m_full[i] && i != g)
            coll = 1'b1;  // requester left waiting
      if (m_full != '0 && g < 0)
         m_idle++;
      if (mode[1] && coll)
      begin
         if (&m_therm[N-2:0])
         begin
            m_therm = '0;
            m_wraps++;
         end
         else
            m_therm = {m_therm[N-2:0], 1'b1};
      end
      if (take)
      begin
         m_ov = (g >= 0);
         if (g >= 0)
         begin
            m_od = m_data[g];  // old payload before any reload
            m_os = IW'(g);
         end
      end
      for (int i = 0; i < N; i++)
      begin
         if (in_valid[i] && rdy[i])
         begin
            m_full[i] = 1'b1;
            m_data[i] = in_data[i*DW +: DW];
            sb_mem[i][sb_tail[i]] = in_data[i*DW +: DW];
            sb_tail[i]++;
         end
         else if (g == i && take)
            m_full[i] = 1'b0;
      end
      @(posedge clk);
      #1;
   endtask

   // bounded run until the model says all is out
   task automatic drain_dut();
      int cycles;
      cycles    = 0;
      in_valid  = '0;
      mask      = '0;
      out_ready = 1'b1;
      while ((m_full != '0 || m_ov) && cycles < DRAIN_LIMIT)
      begin
         check_and_step();
         cycles++;
      end
      if (m_full != '0 || m_ov)
         report_error("mux did not empty within the drain limit");
      for (int i = 0; i < N; i++)
         if (sb_head[i] != sb_tail[i])
            report_error($sformatf("source %0d lost %0d packets", i, sb_tail[i] - sb_head[i]));
   endtask

   task automatic finish_test(input string name, input int errs_before);
      test_count++;
      $display("test %-12s done, %0d errors", name, err_count - errs_before);
   endtask

   task automatic test_reset();
      int e0;
      e0 = err_count;
      reset_dut();
      #1;
      if (out_valid !== 1'b0)
         report_value("out_valid", 0, out_valid);
      if (in_ready !== '1)
         report_value("in_ready", {N{1'b1}}, in_ready);
      @(posedge clk);
      #1;
      finish_test("reset", e0);
   endtask

   task automatic test_priority();
      int e0;
      e0 = err_count;
      reset_dut();
      new_payloads();
      in_valid = '1;  // all four at one edge
      check_and_step();
      drain_dut();
      if (delivered_n != N)
         report_error($sformatf("%0d packets out instead of %0d", delivered_n, N));
      for (int k = 0; k < delivered_n; k++)
         if (delivered_src[k] != k)
            report_value("out_src", k, delivered_src[k]);
      finish_test("priority", e0);
   endtask

   task automatic test_mask();
      int e0;
      int ones;
      e0   = err_count;
      ones = 0;
      reset_dut();
      mask = 4'b0010;
      new_payloads();
      in_valid = '1;
      check_and_step();
      new_payloads();
      in_valid = 4'b0010;  // source 1 tries again into its full slot
      repeat (8)
      begin
         check_and_step();
         if (in_ready[1] !== 1'b0)
            report_value("in_ready[1]", 0, in_ready[1]);
      end
      for (int k = 0; k < delivered_n; k++)
         if (delivered_src[k] == 1)
            report_error("masked source 1 left the mux");
      drain_dut();  // clears the mask
      for (int k = 0; k < delivered_n; k++)
         if (delivered_src[k] == 1)
            ones++;
      if (ones != 1)
         report_error($sformatf("source 1 left %0d times after unmask", ones));
      finish_test("mask", e0);
   endtask

   task automatic test_reserve();
      int e0;
      e0 = err_count;
      reset_dut();
      mode = MODE_RESERVE;
      repeat (12)
      begin
         new_payloads();
         in_valid = '1;  // keep all slots full
         check_and_step();
      end
      repeat (12)
      begin
         new_payloads();
         in_valid = 4'b0011;  // only the low sources which get covered
         check_and_step();
      end
      drain_dut();
      if (m_wraps == 0)
         report_error("thermometer never wrapped to zero");
      if (m_idle == 0)
         report_error("no cycle with every requester covered");
      finish_test("reserve", e0);
   endtask

   task automatic test_backpressure();
      int            e0;
      logic [DW-1:0] held_data;
      logic [IW-1:0] held_src;
      e0 = err_count;
      reset_dut();
      out_ready = 1'b0;
      new_payloads();
      in_valid = '1;
      check_and_step();  // slots load
      in_valid = '0;
      check_and_step();  // source 0 moves to the output
      held_data = in_data[0 +: DW];  // lowest index wins first
      held_src  = '0;
      repeat (6)
      begin
         check_and_step();
         if (out_data !== held_data)
            report_value("out_data", held_data, out_data);
         if (out_src !== held_src)
            report_value("out_src", held_src, out_src);
         if (in_ready !== 4'b0001)
            report_value("in_ready", 4'b0001, in_ready);
      end
      drain_dut();
      if (delivered_n != N)
         report_error($sformatf("%0d packets out instead of %0d", delivered_n, N));
      for (int k = 0; k < delivered_n; k++)
         if (delivered_src[k] != k)
            report_value("out_src", k, delivered_src[k]);
      finish_test("backpressure", e0);
   endtask

   task automatic test_random();
      int          e0;
      logic [31:0] rnd;
      e0 = err_count;
      reset_dut();
      repeat (RANDOM_CYCLES)
      begin
         rnd       = $random(seed);
         in_valid  = rnd[N-1:0];
         out_ready = rnd[8];
         if (rnd[15:12] == 4'h0)
            mode = rnd[21:20];  // all four codes show up
         new_payloads();
         check_and_step();
      end
      mode = MODE_RESERVE;  // lets covered slots out
      drain_dut();
      if (delivered_n == 0)
         report_error("no random traffic got through");
      finish_test("random", e0);
   endtask

   // watchdog
   initial
   begin
      #((RUN_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
      $display("timeout at %0t, tests did not finish", $time);
      $display("Testbench failed");
      $finish;
   end

   initial
   begin
      seed            = 32'hf6c8d2d0;
      err_count       = 0;
      test_count      = 0;
      total_delivered = 0;
      test_reset();
      test_priority();
      test_mask();
      test_reserve();
      test_backpressure();
      test_random();
      $display("%0d tests, %0d packets delivered, %0d errors",
               test_count, total_delivered, err_count);
      if (err_count == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

//--- sim/umi_mux_chk.sv
`timescale 1ns/1ps

module umi_mux_chk
   import umi_pkg::*;
   #(parameter int N  = UMI_N,   // number of sources
     parameter int DW = UMI_DW   // packet width
   )
   (
   input logic                         clk,
   input logic                         nreset,
   input logic                         out_valid,
   input logic                         out_ready,
   input logic [DW-1:0]                out_data,
   input logic [(N>1?$clog2(N):1)-1:0] out_src,
   input logic [N-1:0]                 grants,   // arbiter internal
   input logic [N-1:0]                 mask
   );

   // output register comes up empty
   a_reset_empty : assert property (@(posedge clk) !nreset |=> !out_valid)
      else $error("out_valid high right after reset");

   // never two winners
   a_grant_onehot : assert property (@(posedge clk) disable iff (!nreset) $onehot0(grants))
      else $error("grants not one-hot or zero");

   // stalled output holds its payload and index
   a_stall_hold : assert property (@(posedge clk) disable iff (!nreset)
      out_valid && !out_ready |=> $stable(out_data) && $stable(out_src))
      else $error("output changed while stalled");

   a_mask_block : assert property (@(posedge clk) disable iff (!nreset) (grants & mask) == '0)
      else $error("masked source granted");

endmodule

bind umi_mux umi_mux_chk #(.N(N), .DW(DW)) i_umi_mux_chk (
   .clk       (clk),
   .nreset    (nreset),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .out_data  (out_data),
   .out_src   (out_src),
   .grants    (grants),
   .mask      (mask)
);

//--- design/umi_mux.sv
`timescale 1ns/1ps

module umi_mux
   import umi_pkg::*;
   #(parameter int N  = UMI_N,   // number of sources
     parameter int DW = UMI_DW   // packet width
   )
   (
   input  logic                         clk,
   input  logic                         nreset,
   input  arb_mode_t                    mode,       // arbitration mode
   input  logic [N-1:0]                 mask,       // 1 disables a source
   input  logic [N-1:0]                 in_valid,
   input  logic [N*DW-1:0]              in_data,    // source i in slice i
   output logic [N-1:0]                 in_ready,
   input  logic                         out_ready,
   output logic                         out_valid,
   output logic [DW-1:0]                out_data,
   output logic [(N>1?$clog2(N):1)-1:0] out_src
   );

   logic [N-1:0]    requests;   // slot full flags
   logic [N-1:0]    grants;     // combinational winner
   logic [N*DW-1:0] slot_data;  // held packets
   logic            take;       // output register free

   // one slot per source
   umi_request_buffer #(.N(N), .DW(DW)) i_umi_request_buffer (
      .clk       (clk),
      .nreset    (nreset),
      .in_valid  (in_valid),
      .in_data   (in_data),
      .grants    (grants),
      .take      (take),
      .in_ready  (in_ready),
      .requests  (requests),
      .slot_data (slot_data)
   );

   // picks one full slot per cycle
   umi_arbiter #(.N(N)) i_umi_arbiter (
      .clk      (clk),
      .nreset   (nreset),
      .mode     (mode),
      .mask     (mask),
      .requests (requests),
      .grants   (grants)
   );

   // registers the winner with its index
   umi_output_stage #(.N(N), .DW(DW)) i_umi_output_stage (
      .clk       (clk),
      .nreset    (nreset),
      .grants    (grants),
      .slot_data (slot_data),
      .out_ready (out_ready),
      .take      (take),
      .out_valid (out_valid),
      .out_data  (out_data),
      .out_src   (out_src)
   );

endmodule

//--- design/umi_output_stage.sv
`timescale 1ns/1ps

module umi_output_stage
   import umi_pkg::*;
   #(parameter int N  = UMI_N,   // number of sources
     parameter int DW = UMI_DW   // packet width
   )
   (
   input  logic                         clk,
   input  logic                         nreset,
   input  logic [N-1:0]                 grants,     // one-hot or zero
   input  logic [N*DW-1:0]              slot_data,  // held packets
   input  logic                         out_ready,
   output logic                         take,       // register can load
   output logic                         out_valid,
   output logic [DW-1:0]                out_data,
   output logic [(N>1?$clog2(N):1)-1:0] out_src     // winning source
   );

   localparam int IW = (N > 1) ? $clog2(N) : 1;  // index width

   logic [DW-1:0] sel_data;   // granted packet
   logic [IW-1:0] sel_src;    // granted index
   logic          any_grant;

   // and-or mux, safe since at most one grant is set
   always_comb
   begin
      sel_data = '0;
      sel_src  = '0;
      for (int i = 0; i < N; i++)
      begin
         if (grants[i])
         begin
            sel_data = sel_data | slot_data[i*DW +: DW];
            sel_src  = sel_src | IW'(i);  // one-hot to binary
         end
      end
   end

   assign any_grant = |grants;

   // empty, or being emptied by downstream this cycle
   assign take = ~out_valid | out_ready;

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         out_valid <= 1'b0;
      else if (take)
         out_valid <= any_grant;  // drops when nothing was granted
   end

   // payload and index hold while stalled
   always_ff @(posedge clk)
   begin
      if (take && any_grant)
      begin
         out_data <= sel_data;
         out_src  <= sel_src;
      end
   end

endmodule

//--- design/umi_request_buffer.sv
`timescale 1ns/1ps

module umi_request_buffer
   import umi_pkg::*;
   #(parameter int N  = UMI_N,   // number of sources
     parameter int DW = UMI_DW   // packet width
   )
   (
   input  logic            clk,
   input  logic            nreset,
   input  logic [N-1:0]    in_valid,
   input  logic [N*DW-1:0] in_data,    // source i in slice i
   input  logic [N-1:0]    grants,     // from arbiter
   input  logic            take,       // output stage accepts
   output logic [N-1:0]    in_ready,
   output logic [N-1:0]    requests,   // full flags
   output logic [N*DW-1:0] slot_data   // held packets
   );

   logic [N-1:0] slot_full;
   logic [N-1:0] slot_free;  // emptied at the coming edge
   logic [N-1:0] slot_load;  // filled at the coming edge

   // a granted slot leaves only when the output can take it
   assign slot_free = grants & {N{take}};

   // ready while empty or while being drained, lets a source stream
   assign in_ready  = ~slot_full | slot_free;

   assign slot_load = in_valid & in_ready;
   assign requests  = slot_full;

   // full flags, load wins over free at the same edge
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         slot_full <= '0;  // all empty, in_ready all high
      end
      else
      begin
         for (int i = 0; i < N; i++)
         begin
            if (slot_load[i])
               slot_full[i] <= 1'b1;
            else if (slot_free[i])
               slot_full[i] <= 1'b0;
         end
      end
   end

   // packet payload, only written on a transfer
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < N; i++)
      begin
         if (slot_load[i])
            slot_data[i*DW +: DW] <= in_data[i*DW +: DW];
      end
   end

   // a stale payload in an empty slot is never granted,
   // the arbiter only sees full flags

endmodule

//--- design/umi_arbiter.sv
`timescale 1ns/1ps

module umi_arbiter
   import umi_pkg::*;
   #(parameter int N = UMI_N  // number of sources
   )
   (
   input  logic         clk,
   input  logic         nreset,
   input  arb_mode_t    mode,      // 0x priority, 1x reserve
   input  logic [N-1:0] mask,      // 1 blocks that source
   input  logic [N-1:0] requests,  // full slots
   output logic [N-1:0] grants     // one-hot or zero
   );

   logic [N-1:0] thermometer;   // covered low indices
   logic [N-1:0] therm_shift;   // next hotter step
   logic [N-1:0] eligible;      // requests still in the race
   logic         reserve_en;
   logic         collision;     // some requester left waiting

   // only bit 1 matters, so 01 behaves like MODE_PRIORITY
   assign reserve_en = mode[1] == MODE_RESERVE[1];

   // masked or covered requests drop out
   assign eligible = requests & ~mask & ~thermometer;

   // fixed priority encoder, lowest eligible index wins
   always_comb
   begin : prio_enc
      logic found;
      found  = 1'b0;
      grants = '0;
      for (int i = 0; i < N; i++)
      begin
         if (eligible[i] && !found)
         begin
            grants[i] = 1'b1;
            found     = 1'b1;  // block the higher ones
         end
      end
   end

   // pushback detect, counts masked requesters too
   assign collision = |(requests & ~grants);

   // shift in a one from bit 0
   assign therm_shift = (thermometer << 1) | 1'b1;

   // thermometer gets hotter on every collision in reserve mode
   // once the lower N-1 bits are hot the shift would reach the
   // top bit, so the mask wraps back to zero instead
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         thermometer <= '0;
      end
      else if (collision && reserve_en)
      begin
         if (therm_shift[N-1])
         begin
            thermometer <= '0;  // wrap, low indices back in
         end
         else
         begin
            thermometer <= therm_shift;
         end
      end
   end

   // take is not looked at here, a stalled output still
   // leaves requesters ungranted and keeps heating the mask
   // while every requester is covered the grant is zero and
   // the collision steps the mask on to the wrap

endmodule

//--- design/umi_pkg.sv
package umi_pkg;

   // arbitration mode code, bit 1 picks reserve
   typedef logic [1:0] arb_mode_t;

   // lowest unmasked index wins
   localparam arb_mode_t MODE_PRIORITY = 2'b00;

   // thermometer mask heats up on collisions
   localparam arb_mode_t MODE_RESERVE  = 2'b10;

   // 01 is accepted and acts as priority
   // 11 acts as reserve

   // default fabric size
   localparam int UMI_N  = 4;   // number of sources
   localparam int UMI_DW = 16;  // packet width in bits

   // the source index width comes from N inside each module
   // so that a narrower or wider mux needs no package edit

endpackage
